// File: Bender.yml
package:
  name: vga_pattern

sources:
  - logic/vga_timing_pkg.sv
  - logic/vga_pixel_pkg.sv
  - logic/sync_gen.sv
  - logic/host_reg_port.sv
  - logic/pattern_render.sv
  - logic/vga_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/vga_tb.sv

// File: flist.f
+incdir+verification
logic/vga_timing_pkg.sv
logic/vga_pixel_pkg.sv
logic/sync_gen.sv
logic/host_reg_port.sv
logic/pattern_render.sv
logic/vga_top.sv
verification/vga_tb.sv

// File: logic/host_reg_port.sv
// Write only host port for the palette and the control register.
// Four phase req/ack. cmd must hold while req is high and a new req
// waits for ack low. Writes land in shadow registers and reach the
// live set on frame_start, so a frame never mixes old and new values.
`timescale 1ns/1ps

module host_reg_port import vga_pixel_pkg::*; (
	input  logic      clk25MHz,
	input  logic      rst,
	input  logic      req,
	input  host_cmd_t cmd,
	output logic      ack,
	input  logic      frame_start,
	output palette_t  palette,
	output reg_word_u ctrl
);

	palette_t  shadow_pal;                       // pending palette
	reg_word_u shadow_ctrl;                      // pending control word
	reg_word_u live_ctrl;                        // control word in use
	logic      phase;                            // write taken, waiting for req low
	logic      wr_stb;                           // one strobe per handshake

	assign wr_stb = req && !phase;

	always_ff @(posedge clk25MHz) begin
		if (!rst) begin
			phase <= 1'b0;
			ack   <= 1'b0;
		end else if (wr_stb) begin
			phase <= 1'b1;                       // hold off until req drops
			ack   <= 1'b1;
		end else if (!req) begin
			phase <= 1'b0;
			ack   <= 1'b0;                       // closes the handshake
		end
	end

	// address picks which view of the data word applies
	always_ff @(posedge clk25MHz) begin
		if (!rst) begin
			shadow_pal  <= '0;
			shadow_ctrl <= '0;
		end else if (wr_stb) begin
			if (cmd.addr < CTRL_ADDR) begin
				shadow_pal[cmd.addr[PAL_IDX_W-1:0]] <= cmd.data.colour;
			end else if (cmd.addr == CTRL_ADDR) begin
				shadow_ctrl.ctrl.mode        <= cmd.data.ctrl.mode;
				shadow_ctrl.ctrl.solid_index <= cmd.data.ctrl.solid_index;
				shadow_ctrl.ctrl.rsvd        <= '0;
			end
		end
	end

	always_ff @(posedge clk25MHz) begin
		if (!rst) begin
			palette   <= '0;                     // all black
			live_ctrl <= '0;                     // solid, entry 0
		end else if (frame_start) begin
			palette   <= shadow_pal;
			live_ctrl <= shadow_ctrl;
		end
	end

	// The renderer picks its index from pixel 0,0 in the frame_start cycle,
	// one clock before the palette read, so the new control word is
	// forwarded in that cycle to keep the whole frame on one setting.
	assign ctrl = frame_start ? shadow_ctrl : live_ctrl;

	// ack goes high on the edge that saw req, the host may drop req right after
	a_ack_needs_req: assert property (@(posedge clk25MHz) disable iff (!rst)
		$rose(ack) |-> $past(req))
		else $error("ack rose while req was low");

	a_cmd_stable: assert property (@(posedge clk25MHz) disable iff (!rst)
		req && $past(req) |-> $stable(cmd))
		else $error("cmd changed while req was high");

endmodule

// File: logic/pattern_render.sv
// Two stage renderer from screen position to 12 bit colour.
// Stage one picks a palette index, stage two reads the palette and blanks.
// hsync and vsync ride along so all outputs match one position.
// CHK_SHIFT must be below 11 and H_RES should be a multiple of 8.
`timescale 1ns/1ps

module pattern_render import vga_timing_pkg::*; import vga_pixel_pkg::*; #(
	parameter int H_RES     = 640,
	parameter int CHK_SHIFT = 5
) (
	input  logic        clk25MHz,
	input  logic        rst,
	input  screen_pos_t pos,
	input  palette_t    palette,
	input  reg_word_u   ctrl,
	output rgb444_t     rgb,
	output logic        hsync,
	output logic        vsync
);

	localparam coord_t BAR_W   = coord_t'(H_RES / PAL_ENTRIES); // columns per bar
	localparam coord_t BAR_CNT = coord_t'(PAL_ENTRIES);

	coord_t   bar_num;                           // bar under the column
	pal_idx_t bar_idx;                           // bar clamped to last entry
	logic     chk_bit;
	pal_idx_t idx_nxt;
	pal_idx_t idx_q;                             // stage one palette index
	logic     active_q;
	logic     hsync_q;
	logic     vsync_q;

	assign bar_num = pos.col / BAR_W;
	assign bar_idx = (bar_num >= BAR_CNT) ? '1 : bar_num[PAL_IDX_W-1:0]; // blanking tail
	assign chk_bit = pos.col[CHK_SHIFT] ^ pos.row[CHK_SHIFT];

	always_comb begin
		idx_nxt = ctrl.ctrl.solid_index;         // solid unless a mode says otherwise
		case (ctrl.ctrl.mode)
			BARS: begin
				idx_nxt = bar_idx;
			end
			CHECKER: begin
				idx_nxt = {{(PAL_IDX_W-1){1'b0}}, chk_bit}; // entry 0 or 1
			end
			SOLID, MODE_RSVD: begin
				idx_nxt = ctrl.ctrl.solid_index;
			end
			default: begin
				idx_nxt = ctrl.ctrl.solid_index;
			end
		endcase
	end

	always_ff @(posedge clk25MHz) begin
		idx_q <= idx_nxt;                        // index for the palette read
	end

	always_ff @(posedge clk25MHz) begin
		if (!rst) begin
			active_q <= 1'b0;
			hsync_q  <= 1'b1;
			vsync_q  <= 1'b1;
		end else begin
			active_q <= pos.active;
			hsync_q  <= pos.hsync;
			vsync_q  <= pos.vsync;
		end
	end

	// stage two, palette read and blanking
	always_ff @(posedge clk25MHz) begin
		if (!rst) begin
			rgb   <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end else begin
			rgb   <= active_q ? palette[idx_q] : '0; // black outside visible area
			hsync <= hsync_q;
			vsync <= vsync_q;
		end
	end

endmodule

// File: logic/sync_gen.sv
// Raster counters and sync generation for a VGA style display.
// All pos fields and frame_start are registered one cycle behind the counters.
// Porch and sync widths must be nonzero and the totals must fit in 11 bits.
`timescale 1ns/1ps

module sync_gen import vga_timing_pkg::*; #(
	parameter int H_RES        = 640,
	parameter int H_FPORCH     = 16,
	parameter int H_SYNC_WIDTH = 96,
	parameter int H_BPORCH     = 48,
	parameter int V_RES        = 480,
	parameter int V_FPORCH     = 10,
	parameter int V_SYNC_WIDTH = 2,
	parameter int V_BPORCH     = 33
) (
	input  logic        clk25MHz,
	input  logic        rst,
	output screen_pos_t pos,
	output logic        frame_start
);

	localparam int H_TOTAL = H_RES + H_FPORCH + H_SYNC_WIDTH + H_BPORCH; // clocks per line
	localparam int V_TOTAL = V_RES + V_FPORCH + V_SYNC_WIDTH + V_BPORCH; // lines per frame

	localparam coord_t H_LAST     = coord_t'(H_TOTAL - 1);
	localparam coord_t V_LAST     = coord_t'(V_TOTAL - 1);
	localparam coord_t H_VIS      = coord_t'(H_RES);
	localparam coord_t V_VIS      = coord_t'(V_RES);
	localparam coord_t H_SYNC_ON  = coord_t'(H_RES + H_FPORCH);   // first low column
	localparam coord_t H_SYNC_OFF = coord_t'(H_RES + H_FPORCH + H_SYNC_WIDTH);
	localparam coord_t V_SYNC_ON  = coord_t'(V_RES + V_FPORCH);   // first low line
	localparam coord_t V_SYNC_OFF = coord_t'(V_RES + V_FPORCH + V_SYNC_WIDTH);

	coord_t col_cnt;                             // free running column
	coord_t row_cnt;                             // free running line
	logic   hsync_nxt;
	logic   vsync_nxt;
	logic   active_nxt;

	always_ff @(posedge clk25MHz) begin
		if (!rst) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (col_cnt == H_LAST) begin
			col_cnt <= '0;                       // end of line
			if (row_cnt == V_LAST) begin
				row_cnt <= '0;                   // end of frame
			end else begin
				row_cnt <= row_cnt + 1'b1;
			end
		end else begin
			col_cnt <= col_cnt + 1'b1;
		end
	end

	// porch compares on the raw counters
	assign hsync_nxt  = !((col_cnt >= H_SYNC_ON) && (col_cnt < H_SYNC_OFF));
	assign vsync_nxt  = !((row_cnt >= V_SYNC_ON) && (row_cnt < V_SYNC_OFF));
	assign active_nxt = (col_cnt < H_VIS) && (row_cnt < V_VIS);

	always_ff @(posedge clk25MHz) begin
		if (!rst) begin
			pos         <= POS_IDLE;
			frame_start <= 1'b0;
		end else begin
			pos.col     <= col_cnt;
			pos.row     <= row_cnt;
			pos.hsync   <= hsync_nxt;
			pos.vsync   <= vsync_nxt;
			pos.active  <= active_nxt;
			frame_start <= (col_cnt == '0) && (row_cnt == '0); // marks pos 0,0
		end
	end

	// a sync pulse that starts must last the full width and then end
	a_hsync_width: assert property (@(posedge clk25MHz) disable iff (!rst)
		$fell(pos.hsync) |-> !pos.hsync [*H_SYNC_WIDTH] ##1 pos.hsync)
		else $error("hsync low time differs from %0d cycles", H_SYNC_WIDTH);

	a_col_range: assert property (@(posedge clk25MHz) disable iff (!rst)
		col_cnt < coord_t'(H_TOTAL))
		else $error("column counter reached line total %0d", H_TOTAL);

endmodule

// File: logic/vga_pixel_pkg.sv
// Colour, palette and host register types.
// Host addresses 0 to 7 hit palette entries and 8 hits control.
// Any other address is acknowledged and dropped.
// The reserved mode code is drawn like SOLID.
package vga_pixel_pkg;

	localparam int         PAL_ENTRIES = 8;      // palette depth
	localparam int         PAL_IDX_W   = 3;      // bits to pick an entry
	localparam logic [3:0] CTRL_ADDR   = 4'd8;   // control register address

	typedef logic [PAL_IDX_W-1:0] pal_idx_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb444_t;

	typedef enum logic [1:0] {
		SOLID     = 2'd0,                        // one flat colour
		BARS      = 2'd1,                        // eight vertical bars
		CHECKER   = 2'd2,                        // two colour checkerboard
		MODE_RSVD = 2'd3                         // falls back to solid
	} render_mode_e;

	// control register layout, mode in the top bits
	typedef struct packed {
		render_mode_e mode;
		pal_idx_t     solid_index;               // entry used by solid mode
		logic [6:0]   rsvd;                      // written as zero
	} reg_ctrl_t;

	// one data word, read as a colour or as control by address
	typedef union packed {
		rgb444_t   colour;                       // palette addresses
		reg_ctrl_t ctrl;                         // control address
	} reg_word_u;

	typedef struct packed {
		logic [3:0] addr;
		reg_word_u  data;
	} host_cmd_t;

	typedef rgb444_t [PAL_ENTRIES-1:0] palette_t; // 96 bits, entry 0 lowest

endpackage

// File: logic/vga_timing_pkg.sv
// Screen position types shared by the sync generator and the renderer.
// Coordinates are 11 bits, so the line and frame totals must stay below 2048.
// Both sync levels are active low.
package vga_timing_pkg;

	localparam int COORD_W = 11;                 // covers 800 columns and 525 rows

	typedef logic [COORD_W-1:0] coord_t;         // one column or row count

	// one registered sample of the raster position
	typedef struct packed {
		coord_t col;                             // column inside the line
		coord_t row;                             // line inside the frame
		logic   hsync;                           // low during horizontal sync
		logic   vsync;                           // low during vertical sync
		logic   active;                          // high in the visible area
	} screen_pos_t;

	// the value pos holds in reset, syncs idle and the area blanked
	localparam screen_pos_t POS_IDLE = '{
		col:    '0,
		row:    '0,
		hsync:  1'b1,
		vsync:  1'b1,
		active: 1'b0
	};

endpackage

// File: logic/vga_top.sv
// VGA test pattern generator top level.
// Timing defaults give 640x480 at a 25 MHz pixel clock.
// rgb, hsync and vsync lag the raster counters by three clocks.
`timescale 1ns/1ps

module vga_top import vga_timing_pkg::*; import vga_pixel_pkg::*; #(
	parameter int H_RES        = 640,
	parameter int H_FPORCH     = 16,
	parameter int H_SYNC_WIDTH = 96,
	parameter int H_BPORCH     = 48,
	parameter int V_RES        = 480,
	parameter int V_FPORCH     = 10,
	parameter int V_SYNC_WIDTH = 2,
	parameter int V_BPORCH     = 33,
	parameter int CHK_SHIFT    = 5
) (
	input  logic      clk25MHz,
	input  logic      rst,
	input  logic      req,
	input  host_cmd_t cmd,
	output logic      ack,
	output rgb444_t   rgb,
	output logic      hsync,
	output logic      vsync
);

	screen_pos_t pos;                            // raster position to renderer
	logic        frame_start;                    // live register update strobe
	palette_t    palette;
	reg_word_u   ctrl;

	sync_gen #(
		.H_RES        (H_RES),
		.H_FPORCH     (H_FPORCH),
		.H_SYNC_WIDTH (H_SYNC_WIDTH),
		.H_BPORCH     (H_BPORCH),
		.V_RES        (V_RES),
		.V_FPORCH     (V_FPORCH),
		.V_SYNC_WIDTH (V_SYNC_WIDTH),
		.V_BPORCH     (V_BPORCH)
	) sync_gen_i (
		.clk25MHz    (clk25MHz),
		.rst         (rst),
		.pos         (pos),
		.frame_start (frame_start)
	);

	host_reg_port host_reg_port_i (
		.clk25MHz    (clk25MHz),
		.rst         (rst),
		.req         (req),
		.cmd         (cmd),
		.ack         (ack),
		.frame_start (frame_start),
		.palette     (palette),
		.ctrl        (ctrl)
	);

	pattern_render #(
		.H_RES     (H_RES),
		.CHK_SHIFT (CHK_SHIFT)
	) pattern_render_i (
		.clk25MHz (clk25MHz),
		.rst      (rst),
		.pos      (pos),
		.palette  (palette),
		.ctrl     (ctrl),
		.rgb      (rgb),
		.hsync    (hsync),
		.vsync    (vsync)
	);

endmodule

// File: verification/vga_tb_checks.svh
// Compare tasks, error counters and the LFSR for the VGA testbench.
// Included inside vga_tb after the package imports, so rgb444_t is visible.
// An LFSR seed of zero locks the generator at zero.
`ifndef VGA_TB_CHECKS_SVH
`define VGA_TB_CHECKS_SVH

int value_errs = 0;                              // wrong output values
int proto_errs = 0;                              // missing acks, edges, frames

// colour compare, name carries the pixel position
task automatic check_rgb(input string name, input rgb444_t exp, input rgb444_t act);
	if (act !== exp) begin
		value_errs++;
		$display("ERR %s: expected %h got %h", name, exp, act);
	end
endtask

// single wire levels such as the syncs and ack
task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		value_errs++;
		$display("ERR %s: expected %h got %h", name, exp, act);
	end
endtask

// event counts gathered over a whole frame
task automatic check_count(input string name, input int exp, input int act);
	if (act != exp) begin
		value_errs++;
		$display("ERR %s: expected %h got %h", name, exp, act);
	end
endtask

task automatic report_fault(input string msg);
	proto_errs++;
	$display("error: %s", msg);
endtask

// galois form, right shift, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0]) begin
		return (s >> 1) ^ 32'h8020_0003;
	end
	return s >> 1;
endfunction

`endif

// File: verification/vga_tb.sv
// Directed testbench for vga_top on a 48x22 clock screen with 32x16 visible.
// Output position is recovered from the first hsync and vsync falls, then
// free runs, so every later sync level is checked against the count.
// Expected colours come from a frame level model of palette and mode.
// Host writes must not overlap the last few clocks of a frame.
`timescale 1ns/1ps

module vga_tb import vga_pixel_pkg::*; ();

	localparam int H_RES        = 32;
	localparam int H_FPORCH     = 4;
	localparam int H_SYNC_WIDTH = 8;
	localparam int H_BPORCH     = 4;
	localparam int V_RES        = 16;
	localparam int V_FPORCH     = 2;
	localparam int V_SYNC_WIDTH = 2;
	localparam int V_BPORCH     = 2;
	localparam int CHK_SHIFT    = 2;
	localparam int H_TOTAL      = H_RES + H_FPORCH + H_SYNC_WIDTH + H_BPORCH; // 48
	localparam int V_TOTAL      = V_RES + V_FPORCH + V_SYNC_WIDTH + V_BPORCH; // 22
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int H_SYNC_ON    = H_RES + H_FPORCH;   // first low column
	localparam int V_SYNC_ON    = V_RES + V_FPORCH;   // first low line
	localparam int ACK_WAIT     = 16;                 // clocks before a missing ack
	localparam int TEST_FRAMES  = 8;                  // reset frame up to the last checked one
	localparam int HS_WRITES    = 16;                 // 13 writes rounded up
	localparam int HS_CYCLES    = 4;
	localparam int CYCLE_LIMIT  = (TEST_FRAMES + 2) * FRAME_CYCLES + HS_WRITES * HS_CYCLES;
	localparam logic [31:0] LFSR_SEED = 32'hf049008a;

	logic      clk25MHz = 1'b0;
	logic      rst;
	logic      req;
	host_cmd_t cmd;
	logic      ack;
	rgb444_t   rgb;
	logic      hsync;
	logic      vsync;

	// reference model, pending writes go live at each output frame start
	rgb444_t      live_pal [PAL_ENTRIES] = '{default: '0};
	rgb444_t      pend_pal [PAL_ENTRIES] = '{default: '0};
	render_mode_e live_mode  = SOLID;
	render_mode_e pend_mode  = SOLID;
	int           live_index = 0;
	int           pend_index = 0;

	int          trk_col    = 0;                    // position shown on the outputs
	int          trk_row    = 0;
	logic        h_locked   = 1'b0;
	logic        v_locked   = 1'b0;
	logic        prev_hsync = 1'b1;
	logic        prev_vsync = 1'b1;
	logic [31:0] lfsr_state = LFSR_SEED;
	int          cycle_cnt  = 0;

	`include "vga_tb_checks.svh"

	vga_top #(
		.H_RES        (H_RES),
		.H_FPORCH     (H_FPORCH),
		.H_SYNC_WIDTH (H_SYNC_WIDTH),
		.H_BPORCH     (H_BPORCH),
		.V_RES        (V_RES),
		.V_FPORCH     (V_FPORCH),
		.V_SYNC_WIDTH (V_SYNC_WIDTH),
		.V_BPORCH     (V_BPORCH),
		.CHK_SHIFT    (CHK_SHIFT)
	) vga_top_i (
		.clk25MHz (clk25MHz),
		.rst      (rst),
		.req      (req),
		.cmd      (cmd),
		.ack      (ack),
		.rgb      (rgb),
		.hsync    (hsync),
		.vsync    (vsync)
	);

	always #20 clk25MHz = ~clk25MHz;                 // 40 ns period

	always @(posedge clk25MHz) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("run stopped at cycle %0d before the tests ended", cycle_cnt);
			$display("errors: %0d wrong values, %0d protocol faults", value_errs, proto_errs);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic rgb444_t expected_colour(input int col, input int row);
		int idx;
		if (col >= H_RES || row >= V_RES) begin
			return '0;                               // blanking
		end
		case (live_mode)
			BARS:    idx = col / (H_RES / PAL_ENTRIES);
			CHECKER: idx = ((col >> CHK_SHIFT) ^ (row >> CHK_SHIFT)) & 1;
			default: idx = live_index;               // solid and reserved code
		endcase
		return live_pal[idx];
	endfunction

	task automatic random_colour(output rgb444_t c);
		int b;
		c = '0;
		for (b = 0; b < 12; b++) begin
			c = rgb444_t'({c[10:0], lfsr_state[0]}); // one bit per step
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// one falling edge: advance tracker, then check syncs and colour
	task automatic step_pixel();
		@(negedge clk25MHz);
		if (trk_col == H_TOTAL - 1) begin
			trk_col = 0;
			trk_row = (trk_row == V_TOTAL - 1) ? 0 : trk_row + 1;
		end else begin
			trk_col++;
		end
		if (!h_locked && prev_hsync && !hsync) begin
			trk_col  = H_SYNC_ON;                    // first hsync low sample
			h_locked = 1'b1;
		end
		if (h_locked && !v_locked && prev_vsync && !vsync) begin
			trk_row  = V_SYNC_ON;                    // vsync drops at column 0
			v_locked = 1'b1;
		end
		prev_hsync = hsync;
		prev_vsync = vsync;
		if (v_locked) begin
			if (trk_col == 0 && trk_row == 0) begin
				live_pal   = pend_pal;
				live_mode  = pend_mode;
				live_index = pend_index;
			end
			check_bit("hsync", !(trk_col >= H_SYNC_ON && trk_col < H_SYNC_ON + H_SYNC_WIDTH),
				hsync);
			check_bit("vsync", !(trk_row >= V_SYNC_ON && trk_row < V_SYNC_ON + V_SYNC_WIDTH),
				vsync);
			check_rgb($sformatf("rgb at col %0d row %0d", trk_col, trk_row),
				expected_colour(trk_col, trk_row), rgb);
		end
	endtask

	task automatic wait_frame_start();
		int n;
		n = 0;
		do begin
			step_pixel();
			n++;
		end while (!(trk_col == 0 && trk_row == 0) && n <= FRAME_CYCLES);
		if (!(trk_col == 0 && trk_row == 0)) begin
			report_fault("no frame start seen within one frame");
		end
	endtask

	// four phase write, model takes the data once ack is seen
	task automatic host_write(input logic [3:0] addr, input reg_word_u data);
		int waited;
		req      = 1'b1;
		cmd.addr = addr;
		cmd.data = data;
		waited   = 0;
		while (ack !== 1'b1 && waited < ACK_WAIT) begin
			step_pixel();
			waited++;
		end
		req = 1'b0;
		if (ack !== 1'b1) begin
			report_fault($sformatf("no ack for write to address %0d", addr));
			return;
		end
		waited = 0;
		while (ack !== 1'b0 && waited < ACK_WAIT) begin
			step_pixel();
			waited++;
		end
		if (ack !== 1'b0) begin
			report_fault($sformatf("ack stayed high after write to address %0d", addr));
		end
		if (addr < 4'd8) begin
			pend_pal[addr[2:0]] = data.colour;
		end else if (addr == 4'd8) begin
			pend_mode  = data.ctrl.mode;
			pend_index = data.ctrl.solid_index;
		end                                          // other addresses dropped
	endtask

	task automatic write_ctrl(input render_mode_e mode, input int index);
		reg_word_u data;
		data                  = '0;
		data.ctrl.mode        = mode;
		data.ctrl.solid_index = 3'(index);
		host_write(CTRL_ADDR, data);
	endtask

	task automatic test_reset_idle();
		int n;
		n = 0;
		while (!h_locked && n < H_TOTAL + 8) begin
			check_bit("hsync", 1'b1, hsync);
			check_bit("vsync", 1'b1, vsync);
			check_bit("ack", 1'b0, ack);
			check_rgb("rgb", '0, rgb);
			step_pixel();
			n++;
		end
		if (!h_locked) begin
			report_fault("hsync never fell after reset");
		end
	endtask

	task automatic test_sync_timing();
		int n;
		int h_low;
		int v_low;
		n = 0;
		while (!v_locked && n < 2 * FRAME_CYCLES) begin
			step_pixel();
			n++;
		end
		if (!v_locked) begin
			report_fault("vsync never fell within two frames");
			return;
		end
		wait_frame_start();
		h_low = 0;
		v_low = 0;
		for (n = 0; n < FRAME_CYCLES; n++) begin
			if (n > 0) begin
				step_pixel();
			end
			if (!hsync) h_low++;
			if (!vsync) v_low++;
		end
		check_count("hsync low cycles per frame", V_TOTAL * H_SYNC_WIDTH, h_low);
		check_count("vsync low cycles per frame", V_SYNC_WIDTH * H_TOTAL, v_low);
	endtask

	task automatic test_solid();
		rgb444_t   c;
		reg_word_u data;
		int        i;
		wait_frame_start();
		for (i = 0; i < PAL_ENTRIES; i++) begin
			random_colour(c);
			data        = '0;
			data.colour = c;
			host_write(4'(i), data);
		end
		write_ctrl(SOLID, 5);
		wait_frame_start();                          // frame of entry 5 begins
	endtask

	task automatic test_bars();
		rgb444_t   c;
		reg_word_u data;
		write_ctrl(BARS, 0);
		wait_frame_start();
		while (trk_row != V_RES / 2) begin
			step_pixel();
		end
		random_colour(c);
		if (c == pend_pal[2]) begin
			c = ~c;                                  // make sure bar 2 changes
		end
		data        = '0;
		data.colour = c;
		host_write(4'd2, data);                      // held until the next frame
		wait_frame_start();
	endtask

	task automatic test_checker();
		write_ctrl(CHECKER, 0);
		wait_frame_start();
	endtask

	task automatic test_ignored_addr();
		reg_word_u data;
		data                  = '0;
		data.ctrl.mode        = BARS;                // visible if taken as control
		data.ctrl.solid_index = 3'd4;
		host_write(4'd12, data);
		wait_frame_start();
		wait_frame_start();                          // whole unchanged frame checked
	endtask

	initial begin
		rst = 1'b0;
		req = 1'b0;
		cmd = '0;
		repeat (4) @(posedge clk25MHz);
		@(negedge clk25MHz);
		rst = 1'b1;
		test_reset_idle();
		test_sync_timing();
		test_solid();
		test_bars();
		test_checker();
		test_ignored_addr();
		$display("errors: %0d wrong values, %0d protocol faults", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
